// ==== list.f ====
rx_fifo_pkg.sv
rx_frame_ingest.sv
rx_packet_buffer.sv
rx_header_queue.sv
rx_frame_forwarder.sv
rx_fifo.sv
rx_fifo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status is the simulator's
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module rx_fifo_tb -f list.f -o rx_fifo_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rx_fifo_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi
exit 0

// ==== rx_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fifo_tb;

	localparam int FIFO_LINES = 512;

	// One bit per outcome strobe in port order
	localparam logic[4:0] OUT_NONE		= 5'b00000;
	localparam logic[4:0] OUT_QUEUED	= 5'b10000;
	localparam logic[4:0] OUT_VLAN		= 5'b01000;
	localparam logic[4:0] OUT_RUNT		= 5'b00100;
	localparam logic[4:0] OUT_JUMBO		= 5'b00010;
	localparam logic[4:0] OUT_FIFO		= 5'b00001;

	logic							fabric_clk;
	logic							rst;
	rx_fifo_pkg::rx_bus_t			rx_bus;
	rx_fifo_pkg::port_vlan_cfg_t	vlan_cfg;
	logic							queued;
	logic							drop_vlan;
	logic							drop_runt;
	logic							drop_jumbo;
	logic							drop_fifo;
	logic							fabric_fwd_en;
	logic							fabric_pop;
	rx_fifo_pkg::fabric_bus_t		fabric_bus;

	// Reference model of the frames queued and not yet popped
	rx_fifo_pkg::frame_header_t	exp_hdr_q[$];
	logic[7:0]					exp_bytes_q[$];
	int							committed_lines;

	// Payload of the frame being sent
	logic[7:0]	payload[2048];
	int			words_sent;
	int			cycles;

	rx_fifo u_dut (
		.fabric_clk(fabric_clk),
		.rst(rst),
		.rx_bus(rx_bus),
		.vlan_cfg(vlan_cfg),
		.queued(queued),
		.drop_vlan(drop_vlan),
		.drop_runt(drop_runt),
		.drop_jumbo(drop_jumbo),
		.drop_fifo(drop_fifo),
		.fabric_fwd_en(fabric_fwd_en),
		.fabric_pop(fabric_pop),
		.fabric_bus(fabric_bus)
	);

	always #4 fabric_clk = ~fabric_clk;

	////////////////////////////////////////
	// Error reporting and checks

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Limit grows with the traffic sent
	always @(posedge fabric_clk) begin
		cycles = cycles + 1;
		if (cycles > 40 * words_sent + 10000)
			report_error($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycles));
	end

	function automatic string outcome_name(input logic[4:0] o);
		case (o)
			OUT_NONE:	return "none";
			OUT_QUEUED:	return "queued";
			OUT_VLAN:	return "drop_vlan";
			OUT_RUNT:	return "drop_runt";
			OUT_JUMBO:	return "drop_jumbo";
			OUT_FIFO:	return "drop_fifo";
			default:	return $sformatf("several (%b)", o);
		endcase
	endfunction

	task automatic compare_outcome(input logic[4:0] exp, input logic[4:0] got);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: outcome strobe expected %s got %s",
				$time, outcome_name(exp), outcome_name(got)));
	endtask

	task automatic compare_header(input rx_fifo_pkg::frame_header_t exp,
		input rx_fifo_pkg::frame_header_t got);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: frame header expected %h got %h",
				$time, exp, got));
	endtask

	task automatic compare_word(input int idx, input rx_fifo_pkg::fabric_bus_t exp,
		input rx_fifo_pkg::fabric_bus_t got);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: fabric_bus word %0d expected %h got %h",
				$time, idx, exp, got));
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic got);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
	endtask

	////////////////////////////////////////
	// Ingest side

	// Start cycle with headers then 32-bit words with commit on the last one
	task automatic send_frame(input rx_fifo_pkg::port_vlan_cfg_t cfg,
		input rx_fifo_pkg::frame_header_t hdr, input logic tagged_frame,
		input rx_fifo_pkg::vlan_id_t tag_vlan, input int abort_at);
		int			len;
		int			nwords;
		logic[31:0]	word;
		len = int'(hdr.len);
		nwords = (len + 3) / 4;
		@(posedge fabric_clk);
		#1;
		vlan_cfg				= cfg;
		rx_bus					= '0;
		rx_bus.start			= 1'b1;
		rx_bus.headers_valid	= 1'b1;
		rx_bus.dst_mac			= hdr.dst_mac;
		rx_bus.src_mac			= hdr.src_mac;
		rx_bus.ethertype		= hdr.ethertype;
		rx_bus.has_vlan_tag		= tagged_frame;
		rx_bus.vlan_id			= tag_vlan;
		for (int w = 0; w < nwords; w++) begin
			@(posedge fabric_clk);
			#1;
			rx_bus.start = 1'b0;
			// MAC abort in place of a data word
			if (w == abort_at) begin
				rx_bus.data_valid	= 1'b0;
				rx_bus.drop			= 1'b1;
				break;
			end
			word = '0;
			for (int k = 0; k < 4; k++)
				if (4 * w + k < len)
					word[31 - 8 * k -: 8] = payload[4 * w + k];
			rx_bus.data_valid	= 1'b1;
			rx_bus.data			= word;
			rx_bus.bytes_valid	= (w == nwords - 1) ? 3'(len - 4 * w) : 3'd4;
			rx_bus.commit		= (w == nwords - 1);
			words_sent++;
		end
		@(posedge fabric_clk);
		#1;
		rx_bus = '0;
	endtask

	// Exactly one strobe no later than commit plus 3
	task automatic check_outcome(input logic[4:0] exp);
		logic[4:0]	seen;
		logic[4:0]	now;
		int			pulses;
		seen = OUT_NONE;
		pulses = 0;
		for (int i = 0; i < 6; i++) begin
			@(negedge fabric_clk);
			now = {queued, drop_vlan, drop_runt, drop_jumbo, drop_fifo};
			if (now != OUT_NONE) begin
				pulses++;
				seen = now;
				if (i > 2)
					report_error($sformatf("Outcome strobe came too late after commit at %0t", $time));
			end
		end
		if (pulses > 1)
			report_error($sformatf("More than one outcome strobe for one frame at %0t", $time));
		compare_outcome(exp, seen);
	endtask

	// Mode 0 is an access port, 1 a native VLAN port and 2 a trunk
	task automatic run_frame(input int mode, input logic tagged_frame, input int len,
		input int abort_at, output logic[4:0] exp);
		rx_fifo_pkg::port_vlan_cfg_t	cfg;
		rx_fifo_pkg::frame_header_t		hdr;
		rx_fifo_pkg::vlan_id_t			tag_vlan;
		int								lines;
		cfg.has_port_vlan		= (mode != 2);
		cfg.port_vlan_id		= 12'($urandom);
		cfg.native_vlan_allowed	= (mode == 1);
		tag_vlan		= 12'($urandom);
		hdr.len			= 11'(len);
		hdr.ethertype	= 16'($urandom);
		hdr.src_mac		= {16'($urandom), 32'($urandom)};
		hdr.dst_mac		= {16'($urandom), 32'($urandom)};
		hdr.vlan		= tagged_frame ? tag_vlan : cfg.port_vlan_id;
		for (int i = 0; i < len; i++)
			payload[i] = 8'($urandom);
		lines = (len + 7) / 8;
		// Acceptance rule in priority order
		if ((tagged_frame && mode == 0) || (!tagged_frame && mode == 2))
			exp = OUT_VLAN;
		else if (len + rx_fifo_pkg::L2_HEADER_BYTES > rx_fifo_pkg::MAX_FRAME_BYTES)
			exp = OUT_JUMBO;
		else if (committed_lines + lines > FIFO_LINES - rx_fifo_pkg::FIFO_GUARD_LINES)
			exp = OUT_FIFO;
		else if (len + rx_fifo_pkg::L2_HEADER_BYTES < rx_fifo_pkg::MIN_FRAME_BYTES)
			exp = OUT_RUNT;
		else
			exp = OUT_QUEUED;
		if (abort_at >= 0)
			exp = OUT_NONE;
		send_frame(cfg, hdr, tagged_frame, tag_vlan, abort_at);
		check_outcome(exp);
		if (exp == OUT_QUEUED) begin
			committed_lines += lines;
			exp_hdr_q.push_back(hdr);
			for (int i = 0; i < len; i++)
				exp_bytes_q.push_back(payload[i]);
		end
	endtask

	////////////////////////////////////////
	// Fabric side

	task automatic forward_frame();
		rx_fifo_pkg::frame_header_t	exp_hdr;
		rx_fifo_pkg::frame_header_t	got_hdr;
		rx_fifo_pkg::fabric_bus_t	exp_word;
		logic[7:0]					frame[$];
		int							total;
		int							nwords;
		int							nb;
		int							got_bytes;
		int							waited;
		exp_hdr = exp_hdr_q.pop_front();
		total = int'(exp_hdr.len) + rx_fifo_pkg::L2_HEADER_BYTES;
		nwords = (total + 7) / 8;
		// Untagged frame as it goes out
		for (int i = 5; i >= 0; i--)
			frame.push_back(exp_hdr.dst_mac[8 * i +: 8]);
		for (int i = 5; i >= 0; i--)
			frame.push_back(exp_hdr.src_mac[8 * i +: 8]);
		frame.push_back(exp_hdr.ethertype[15:8]);
		frame.push_back(exp_hdr.ethertype[7:0]);
		for (int i = 0; i < int'(exp_hdr.len); i++)
			frame.push_back(exp_bytes_q.pop_front());
		waited = 0;
		while (fabric_bus.frame_valid !== 1'b1) begin
			@(negedge fabric_clk);
			waited++;
			if (waited > 8)
				report_error($sformatf("frame_valid never rose for a queued frame at %0t", $time));
		end
		got_hdr = '0;
		got_hdr.dst_mac	= fabric_bus.frame_dst_mac;
		got_hdr.src_mac	= fabric_bus.frame_src_mac;
		got_hdr.vlan	= fabric_bus.frame_vlan;

		@(posedge fabric_clk);
		#1;
		fabric_fwd_en = 1'b1;
		@(posedge fabric_clk);
		#1;
		fabric_fwd_en = 1'b0;
		// Words start two cycles after the request
		@(negedge fabric_clk);
		compare_flag("fabric_bus.fwd_valid", 1'b0, fabric_bus.fwd_valid);
		got_bytes = 0;
		for (int w = 0; w < nwords; w++) begin
			@(negedge fabric_clk);
			nb = (total - 8 * w >= 8) ? 8 : total - 8 * w;
			exp_word = '0;
			exp_word.frame_valid		= 1'b1;
			exp_word.frame_dst_mac		= exp_hdr.dst_mac;
			exp_word.frame_src_mac		= exp_hdr.src_mac;
			exp_word.frame_vlan			= exp_hdr.vlan;
			exp_word.fwd_valid			= 1'b1;
			exp_word.fwd_bytes_valid	= 4'(nb);
			for (int k = 0; k < nb; k++)
				exp_word.fwd_data[63 - 8 * k -: 8] = frame[8 * w + k];
			if (w == 1)
				got_hdr.ethertype = fabric_bus.fwd_data[31:16];
			got_bytes += int'(fabric_bus.fwd_bytes_valid);
			compare_word(w, exp_word, fabric_bus);
		end
		@(negedge fabric_clk);
		compare_flag("fabric_bus.fwd_valid", 1'b0, fabric_bus.fwd_valid);
		got_hdr.len = 11'(got_bytes - rx_fifo_pkg::L2_HEADER_BYTES);
		compare_header(exp_hdr, got_hdr);

		@(posedge fabric_clk);
		#1;
		fabric_pop = 1'b1;
		@(posedge fabric_clk);
		#1;
		fabric_pop = 1'b0;
		committed_lines -= (int'(exp_hdr.len) + 7) / 8;
		@(negedge fabric_clk);
		compare_flag("fabric_bus.frame_valid", 1'b0, fabric_bus.frame_valid);
	endtask

	task automatic drain_frames();
		while (exp_hdr_q.size() > 0)
			forward_frame();
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		logic[4:0]	outcome;
		fabric_clk		= 1'b0;
		rst				= 1'b1;
		rx_bus			= '0;
		vlan_cfg		= '0;
		fabric_fwd_en	= 1'b0;
		fabric_pop		= 1'b0;
		committed_lines	= 0;
		words_sent		= 0;
		cycles			= 0;
		void'($urandom(32'h7031_d891));
		repeat (16) @(posedge fabric_clk);
		#1;
		rst = 1'b0;

		// Runt and jumbo bounds on a native VLAN port
		run_frame(1, 1'b0, 45, -1, outcome);
		run_frame(1, 1'b1, 46, -1, outcome);
		run_frame(1, 1'b0, 1586, -1, outcome);
		run_frame(1, 1'b1, 1587, -1, outcome);
		drain_frames();

		// Every port mode with and without a tag
		for (int mode = 0; mode < 3; mode++)
			for (int t = 0; t < 2; t++) begin
				run_frame(mode, t[0], 46 + int'($urandom % 200), -1, outcome);
				drain_frames();
			end

		// Random lengths over and past both bounds
		repeat (60) begin
			run_frame(int'($urandom % 3), 1'($urandom), 30 + int'($urandom % 1591), -1, outcome);
			drain_frames();
		end

		// Abort between two good frames leaves no trace
		run_frame(1, 1'b1, 100, -1, outcome);
		run_frame(1, 1'b0, 400, 30, outcome);
		run_frame(1, 1'b0, 150, -1, outcome);
		drain_frames();

		// Fill without popping until the buffer refuses a frame
		outcome = OUT_NONE;
		while (outcome != OUT_FIFO)
			run_frame(1, 1'($urandom), 46 + int'($urandom % 1541), -1, outcome);
		drain_frames();
		repeat (4)
			run_frame(1, 1'($urandom), 46 + int'($urandom % 1541), -1, outcome);
		drain_frames();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
	parameter int fifo_lines = 512,
	// At least fifo_lines / 4 so the header queue never fills
	parameter int meta_lines = 128
) (
	input wire								fabric_clk,
	input wire								rst,
	input wire rx_fifo_pkg::rx_bus_t		rx_bus,
	input wire rx_fifo_pkg::port_vlan_cfg_t	vlan_cfg,
	output logic							queued,
	output logic							drop_vlan,
	output logic							drop_runt,
	output logic							drop_jumbo,
	output logic							drop_fifo,
	input wire								fabric_fwd_en,
	input wire								fabric_pop,
	output rx_fifo_pkg::fabric_bus_t		fabric_bus
);

	localparam int AW		= $clog2(fifo_lines);
	localparam int CNT_W	= AW + 1;

	// Ingest to packet buffer
	logic						wr_en;
	rx_fifo_pkg::line_t			wr_data;
	logic						wr_commit;
	logic						wr_rollback;
	logic[CNT_W-1:0]			free_lines;

	// Ingest to header queue
	logic						push;
	rx_fifo_pkg::frame_header_t	push_header;

	// Forwarder side
	logic						hdr_pop;
	logic						hdr_empty;
	rx_fifo_pkg::frame_header_t	hdr_data;
	logic[AW-1:0]				rd_offset;
	rx_fifo_pkg::line_t			rd_data;
	logic						pop_packet;
	logic[CNT_W-1:0]			pop_lines;

	rx_frame_ingest #(
		.fifo_lines(fifo_lines)
	) u_ingest (
		.fabric_clk(fabric_clk),
		.rst(rst),
		.rx_bus(rx_bus),
		.vlan_cfg(vlan_cfg),
		.free_lines(free_lines),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.wr_commit(wr_commit),
		.wr_rollback(wr_rollback),
		.push(push),
		.push_header(push_header),
		.queued(queued),
		.drop_vlan(drop_vlan),
		.drop_runt(drop_runt),
		.drop_jumbo(drop_jumbo),
		.drop_fifo(drop_fifo)
	);

	rx_packet_buffer #(
		.fifo_lines(fifo_lines)
	) u_buffer (
		.fabric_clk(fabric_clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.wr_commit(wr_commit),
		.wr_rollback(wr_rollback),
		.free_lines(free_lines),
		.rd_offset(rd_offset),
		.rd_data(rd_data),
		.pop_packet(pop_packet),
		.pop_lines(pop_lines)
	);

	rx_header_queue #(
		.meta_lines(meta_lines)
	) u_headers (
		.fabric_clk(fabric_clk),
		.rst(rst),
		.push(push),
		.push_header(push_header),
		.hdr_pop(hdr_pop),
		.hdr_data(hdr_data),
		.hdr_empty(hdr_empty)
	);

	rx_frame_forwarder #(
		.fifo_lines(fifo_lines)
	) u_forwarder (
		.fabric_clk(fabric_clk),
		.rst(rst),
		.hdr_empty(hdr_empty),
		.hdr_data(hdr_data),
		.hdr_pop(hdr_pop),
		.rd_offset(rd_offset),
		.rd_data(rd_data),
		.pop_packet(pop_packet),
		.pop_lines(pop_lines),
		.fabric_fwd_en(fabric_fwd_en),
		.fabric_pop(fabric_pop),
		.fabric_bus(fabric_bus)
	);

endmodule

`default_nettype wire

// ==== rx_frame_forwarder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_forwarder #(
	parameter int fifo_lines = 512
) (
	input wire								fabric_clk,
	input wire								rst,
	input wire								hdr_empty,
	input wire rx_fifo_pkg::frame_header_t	hdr_data,
	output logic							hdr_pop,
	output logic[$clog2(fifo_lines)-1:0]	rd_offset,
	input wire rx_fifo_pkg::line_t			rd_data,
	output logic							pop_packet,
	output logic[$clog2(fifo_lines):0]		pop_lines,
	input wire								fabric_fwd_en,
	input wire								fabric_pop,
	output rx_fifo_pkg::fabric_bus_t		fabric_bus
);

	localparam int CNT_W = $clog2(fifo_lines) + 1;

	typedef enum logic[2:0] {
		FWD_IDLE,
		FWD_HEADER,
		FWD_FIRST,
		FWD_DATA,
		FWD_LAST
	} fwd_state_t;

	fwd_state_t			state;
	logic				frame_valid;
	logic				fwd_valid;
	logic[3:0]			fwd_bytes_valid;
	rx_fifo_pkg::line_t	fwd_data;
	rx_fifo_pkg::line_t	prev_line;

	// Bytes of the rebuilt frame not yet sent
	logic[11:0]			remaining;

	rx_fifo_pkg::line_t	aligned;
	rx_fifo_pkg::line_t	last_mask;

	// Fetch the next header as soon as nothing is on offer
	assign hdr_pop = !frame_valid && !hdr_empty;

	always_comb begin
		// Payload shifted by the two bytes that rode in the ethertype word
		aligned		= {prev_line[47:0], rd_data[63:48]};
		// Keep the top remaining bytes, zero the padding
		last_mask	= ~(64'hFFFF_FFFF_FFFF_FFFF >> {remaining[3:0], 3'b000});
	end

	always_comb begin
		fabric_bus.frame_valid		= frame_valid;
		fabric_bus.frame_dst_mac	= hdr_data.dst_mac;
		fabric_bus.frame_src_mac	= hdr_data.src_mac;
		fabric_bus.frame_vlan		= hdr_data.vlan;
		fabric_bus.fwd_valid		= fwd_valid;
		fabric_bus.fwd_bytes_valid	= fwd_bytes_valid;
		fabric_bus.fwd_data			= fwd_data;
	end

	////////////////////////////////////////
	// Forward FSM and frame release

	always_ff @(posedge fabric_clk) begin
		prev_line <= rd_data;
		if (rst) begin
			state		<= FWD_IDLE;
			frame_valid	<= 1'b0;
			fwd_valid	<= 1'b0;
			pop_packet	<= 1'b0;
			pop_lines	<= '0;
			rd_offset	<= '0;
			remaining	<= '0;
		end
		else begin
			fwd_valid	<= 1'b0;
			pop_packet	<= 1'b0;

			// Header data shows up with frame_valid
			if (hdr_pop)
				frame_valid <= 1'b1;

			// Free the frame's lines, rounded up to whole lines
			if (fabric_pop) begin
				frame_valid	<= 1'b0;
				pop_packet	<= 1'b1;
				pop_lines	<= CNT_W'(hdr_data.len[10:3]) + CNT_W'(|hdr_data.len[2:0]);
			end

			case (state)
				FWD_IDLE: begin
					if (fabric_fwd_en) begin
						rd_offset	<= '0;
						remaining	<= 12'(hdr_data.len) + 12'(rx_fifo_pkg::L2_HEADER_BYTES);
						state		<= FWD_HEADER;
					end
				end

				// Destination plus top of source, tag is never re-inserted
				FWD_HEADER: begin
					fwd_valid		<= 1'b1;
					fwd_bytes_valid	<= 4'd8;
					fwd_data		<= {hdr_data.dst_mac, hdr_data.src_mac[47:32]};
					rd_offset		<= rd_offset + 1'b1;
					remaining		<= remaining - 12'd8;
					state			<= FWD_FIRST;
				end

				// Rest of source, ethertype, first two payload bytes
				FWD_FIRST: begin
					fwd_valid		<= 1'b1;
					fwd_bytes_valid	<= 4'd8;
					fwd_data		<= {hdr_data.src_mac[31:0], hdr_data.ethertype, rd_data[63:48]};
					rd_offset		<= rd_offset + 1'b1;
					remaining		<= remaining - 12'd8;
					state			<= (remaining > 12'd16) ? FWD_DATA : FWD_LAST;
				end

				// Full payload words, reads run ahead and may wrap harmlessly
				FWD_DATA: begin
					fwd_valid		<= 1'b1;
					fwd_bytes_valid	<= 4'd8;
					fwd_data		<= aligned;
					rd_offset		<= rd_offset + 1'b1;
					remaining		<= remaining - 12'd8;
					if (remaining <= 12'd16)
						state <= FWD_LAST;
				end

				// Final word, 1 to 8 bytes
				FWD_LAST: begin
					fwd_valid		<= 1'b1;
					fwd_bytes_valid	<= remaining[3:0];
					fwd_data		<= aligned & last_mask;
					remaining		<= '0;
					state			<= FWD_IDLE;
				end

				default:
					state <= FWD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rx_header_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_header_queue #(
	parameter int meta_lines = 128
) (
	input wire								fabric_clk,
	input wire								rst,
	input wire								push,
	input wire rx_fifo_pkg::frame_header_t	push_header,
	input wire								hdr_pop,
	output rx_fifo_pkg::frame_header_t		hdr_data,
	output logic							hdr_empty
);

	localparam int AW = $clog2(meta_lines);

	rx_fifo_pkg::frame_header_t	mem[meta_lines];

	// Never fills, a legal frame takes more payload lines than header slots
	logic[AW-1:0]	wr_ptr;
	logic[AW-1:0]	rd_ptr;

	assign hdr_empty = (wr_ptr == rd_ptr);

	// Storage with output register
	always_ff @(posedge fabric_clk) begin
		if (push)
			mem[wr_ptr] <= push_header;
		if (hdr_pop)
			hdr_data <= mem[rd_ptr];
	end

	always_ff @(posedge fabric_clk) begin
		if (rst) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
		end
		else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (hdr_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rx_packet_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_packet_buffer #(
	parameter int fifo_lines = 512
) (
	input wire							fabric_clk,
	input wire							rst,
	input wire							wr_en,
	input wire rx_fifo_pkg::line_t		wr_data,
	input wire							wr_commit,
	input wire							wr_rollback,
	output logic[$clog2(fifo_lines):0]	free_lines,
	input wire[$clog2(fifo_lines)-1:0]	rd_offset,
	output rx_fifo_pkg::line_t			rd_data,
	input wire							pop_packet,
	input wire[$clog2(fifo_lines):0]	pop_lines
);

	localparam int AW		= $clog2(fifo_lines);
	localparam int CNT_W	= AW + 1;

	// Circular line store, depth is a power of two so pointers wrap naturally
	rx_fifo_pkg::line_t	mem[fifo_lines];

	// Tentative write point, last committed frame end, oldest frame start
	logic[AW-1:0]	wr_ptr;
	logic[AW-1:0]	commit_ptr;
	logic[AW-1:0]	rd_base;

	logic[CNT_W-1:0]	committed_cnt;
	logic[CNT_W-1:0]	tentative_cnt;

	assign free_lines = CNT_W'(fifo_lines) - committed_cnt - tentative_cnt;

	////////////////////////////////////////
	// Storage and registered read

	always_ff @(posedge fabric_clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		// Offset is relative to the frame at the head
		rd_data <= mem[rd_base + rd_offset];
	end

	////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge fabric_clk) begin
		if (rst) begin
			wr_ptr			<= '0;
			commit_ptr		<= '0;
			rd_base			<= '0;
			committed_cnt	<= '0;
			tentative_cnt	<= '0;
		end
		else begin
			// Abort rewinds to the last commit point
			if (wr_rollback) begin
				wr_ptr			<= commit_ptr;
				tentative_cnt	<= '0;
			end
			else if (wr_en) begin
				wr_ptr			<= wr_ptr + 1'b1;
				tentative_cnt	<= tentative_cnt + 1'b1;
			end

			// A write landing with the commit already belongs to the next frame
			if (wr_commit) begin
				commit_ptr		<= wr_ptr;
				tentative_cnt	<= CNT_W'(wr_en);
			end

			committed_cnt <= committed_cnt
				+ (wr_commit ? tentative_cnt : '0)
				- (pop_packet ? pop_lines : '0);

			// Release the whole head frame
			if (pop_packet)
				rd_base <= rd_base + pop_lines[AW-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== rx_frame_ingest.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_ingest #(
	parameter int fifo_lines = 512
) (
	input wire							fabric_clk,
	input wire							rst,
	input wire rx_fifo_pkg::rx_bus_t		rx_bus,
	input wire rx_fifo_pkg::port_vlan_cfg_t	vlan_cfg,
	input wire[$clog2(fifo_lines):0]	free_lines,
	output logic						wr_en,
	output rx_fifo_pkg::line_t			wr_data,
	output logic						wr_commit,
	output logic						wr_rollback,
	output logic						push,
	output rx_fifo_pkg::frame_header_t	push_header,
	output logic						queued,
	output logic						drop_vlan,
	output logic						drop_runt,
	output logic						drop_jumbo,
	output logic						drop_fifo
);

	localparam int CNT_W = $clog2(fifo_lines) + 1;

	// Header being built for the current frame, len doubles as byte counter
	rx_fifo_pkg::frame_header_t	hdr_q;
	logic						hv_q;

	// Upper half of a line waiting for its partner word
	logic[31:0]		half;
	logic			half_valid;

	// Sticky drop conditions, cleared at frame start
	logic			vlan_bad;
	logic			too_long;
	logic			overflow;

	logic			pending_end;
	logic[CNT_W-1:0]	lines;

	logic					count;
	logic					take;
	logic					line_req;
	logic					space_ok;
	rx_fifo_pkg::line_t		line_out;
	rx_fifo_pkg::frame_len_t	len_next;
	logic[15:0]				frame_lines;
	logic[15:0]				avail;

	////////////////////////////////////////
	// Line packing

	always_comb begin
		// Length keeps counting past overflow so jumbo still wins
		count		= rx_bus.data_valid && !rx_bus.drop && !vlan_bad;
		take		= count && !too_long && !overflow;
		len_next	= hdr_q.len + rx_fifo_pkg::frame_len_t'(rx_bus.bytes_valid);
		line_req	= 1'b0;
		line_out	= {half, rx_bus.data};
		if (take && half_valid)
			line_req = 1'b1;
		// Last word lands in an upper half, lower half zero
		else if (take && rx_bus.commit) begin
			line_req	= 1'b1;
			line_out	= {rx_bus.data, 32'h0};
		end
		// Flush a lone half at commit
		else if (!take && rx_bus.commit && !rx_bus.drop && half_valid && !too_long && !overflow) begin
			line_req	= 1'b1;
			line_out	= {half, 32'h0};
		end
		// Room for one more line above the guard, counting the one in flight
		space_ok	= free_lines > CNT_W'(rx_fifo_pkg::FIFO_GUARD_LINES) + CNT_W'(wr_en);
		frame_lines	= 16'(hdr_q.len[10:3]) + 16'(|hdr_q.len[2:0]);
		// Lines free of committed data, before this frame wrote anything
		avail		= 16'(free_lines) + 16'(lines) - 16'(wr_en);
	end

	always_ff @(posedge fabric_clk) begin
		if (rst) begin
			wr_en		<= 1'b0;
			wr_commit	<= 1'b0;
			wr_rollback	<= 1'b0;
			push		<= 1'b0;
			queued		<= 1'b0;
			drop_vlan	<= 1'b0;
			drop_runt	<= 1'b0;
			drop_jumbo	<= 1'b0;
			drop_fifo	<= 1'b0;
			hv_q		<= 1'b0;
			hdr_q.len	<= '0;
			half_valid	<= 1'b0;
			vlan_bad	<= 1'b0;
			too_long	<= 1'b0;
			overflow	<= 1'b0;
			pending_end	<= 1'b0;
			lines		<= '0;
		end
		else begin
			wr_en		<= 1'b0;
			wr_commit	<= 1'b0;
			wr_rollback	<= 1'b0;
			push		<= 1'b0;
			queued		<= 1'b0;
			drop_vlan	<= 1'b0;
			drop_runt	<= 1'b0;
			drop_jumbo	<= 1'b0;
			drop_fifo	<= 1'b0;
			pending_end	<= 1'b0;
			hv_q		<= rx_bus.headers_valid;

			if (rx_bus.start) begin
				hdr_q.len	<= '0;
				half_valid	<= 1'b0;
				vlan_bad	<= 1'b0;
				too_long	<= 1'b0;
				overflow	<= 1'b0;
				lines		<= '0;
			end

			// Latch addresses and apply VLAN policy on header arrival
			if (rx_bus.headers_valid && !hv_q) begin
				hdr_q.dst_mac	<= rx_bus.dst_mac;
				hdr_q.src_mac	<= rx_bus.src_mac;
				hdr_q.ethertype	<= rx_bus.ethertype;
				hdr_q.vlan		<= rx_bus.has_vlan_tag ? rx_bus.vlan_id : vlan_cfg.port_vlan_id;
				// Tagged on an access port, or untagged on a trunk
				if (rx_bus.has_vlan_tag)
					vlan_bad <= vlan_cfg.has_port_vlan && !vlan_cfg.native_vlan_allowed;
				else
					vlan_bad <= !vlan_cfg.has_port_vlan;
			end

			if (count) begin
				hdr_q.len <= len_next;
				if (16'(len_next) + 16'(rx_fifo_pkg::L2_HEADER_BYTES) >
					16'(rx_fifo_pkg::MAX_FRAME_BYTES))
					too_long <= 1'b1;
			end
			if (take && !half_valid && !rx_bus.commit) begin
				half		<= rx_bus.data;
				half_valid	<= 1'b1;
			end

			if (line_req) begin
				half_valid <= 1'b0;
				if (space_ok) begin
					wr_en	<= 1'b1;
					wr_data	<= line_out;
					lines	<= lines + 1'b1;
				end
				// Out of room, stop writing and drop at the end
				else
					overflow <= 1'b1;
			end

			if (rx_bus.commit && !rx_bus.drop) begin
				half_valid	<= 1'b0;
				pending_end	<= 1'b1;
			end

			// One cycle after commit the last line is on its way, decide the outcome
			if (pending_end) begin
				if (vlan_bad) begin
					drop_vlan	<= 1'b1;
					wr_rollback	<= 1'b1;
				end
				else if (too_long) begin
					drop_jumbo	<= 1'b1;
					wr_rollback	<= 1'b1;
				end
				else if (overflow || frame_lines + 16'(rx_fifo_pkg::FIFO_GUARD_LINES) > avail) begin
					drop_fifo	<= 1'b1;
					wr_rollback	<= 1'b1;
				end
				else if (16'(hdr_q.len) + 16'(rx_fifo_pkg::L2_HEADER_BYTES) <
					16'(rx_fifo_pkg::MIN_FRAME_BYTES)) begin
					drop_runt	<= 1'b1;
					wr_rollback	<= 1'b1;
				end
				else begin
					queued		<= 1'b1;
					wr_commit	<= 1'b1;
					push		<= 1'b1;
					push_header	<= hdr_q;
				end
			end

			// MAC abort, silently discard whatever was written
			if (rx_bus.drop) begin
				wr_rollback	<= 1'b1;
				half_valid	<= 1'b0;
				hdr_q.len	<= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rx_fifo_pkg.sv ====
`default_nettype none

package rx_fifo_pkg;

	////////////////////////////////////////
	// Basic Ethernet field types

	typedef logic[47:0]	mac_addr_t;
	typedef logic[11:0]	vlan_id_t;
	typedef logic[15:0]	ethertype_t;

	// Payload byte count, bytes after the ethertype
	typedef logic[10:0]	frame_len_t;

	// One line of the packet buffer
	typedef logic[63:0]	line_t;

	////////////////////////////////////////
	// Frame size limits

	// Destination, source and ethertype
	localparam int L2_HEADER_BYTES	= 14;
	localparam int MIN_FRAME_BYTES	= 60;
	localparam int MAX_FRAME_BYTES	= 1600;

	// Lines every frame must leave free in the buffer
	localparam int FIFO_GUARD_LINES	= 2;

	////////////////////////////////////////
	// Buses

	// Decoded frame stream from the MAC side
	typedef struct packed {
		logic		start;
		logic		headers_valid;
		mac_addr_t	dst_mac;
		mac_addr_t	src_mac;
		ethertype_t	ethertype;
		logic		has_vlan_tag;
		vlan_id_t	vlan_id;
		logic		data_valid;
		logic[31:0]	data;
		// 1 to 4, packed from the most significant byte
		logic[2:0]	bytes_valid;
		logic		commit;
		logic		drop;
	} rx_bus_t;

	// Per frame record kept next to the payload
	typedef struct packed {
		frame_len_t	len;
		ethertype_t	ethertype;
		mac_addr_t	src_mac;
		mac_addr_t	dst_mac;
		vlan_id_t	vlan;
	} frame_header_t;

	// Toward the switch fabric
	typedef struct packed {
		logic		frame_valid;
		mac_addr_t	frame_dst_mac;
		mac_addr_t	frame_src_mac;
		vlan_id_t	frame_vlan;
		logic		fwd_valid;
		logic[3:0]	fwd_bytes_valid;
		line_t		fwd_data;
	} fabric_bus_t;

	// Port VLAN policy
	typedef struct packed {
		logic		has_port_vlan;
		vlan_id_t	port_vlan_id;
		// Tagged traffic allowed alongside the port VLAN
		logic		native_vlan_allowed;
	} port_vlan_cfg_t;

endpackage

`default_nettype wire
